//--- verilog/ama_riscv_pkg.sv
`default_nettype none

package ama_riscv_pkg;

// sizes
localparam int XLEN = 32;
localparam int RF_ADDR_W = 5;
localparam int RF_NUM = 1 << RF_ADDR_W;
localparam int DMEM_DEPTH = 64;
localparam int DMEM_ADDR_W = $clog2(DMEM_DEPTH);
localparam int QUEUE_DEPTH = 8;
localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
localparam int PC_W = 16;

typedef logic [RF_ADDR_W-1:0] rf_addr_t;
localparam rf_addr_t RF_X0_ZERO = '0;

typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SLT
} alu_op_t;

typedef enum logic [1:0] {
    ALU_A_SEL_RS1 = 2'd0,
    ALU_A_SEL_PC  = 2'd1,
    ALU_A_SEL_FWD = 2'd2
} alu_a_sel_t;

typedef enum logic [1:0] {
    ALU_B_SEL_RS2 = 2'd0,
    ALU_B_SEL_IMM = 2'd1,
    ALU_B_SEL_FWD = 2'd2
} alu_b_sel_t;

// EWBK is the memory stage alu result, WBK the writeback data
typedef enum logic {
    FWD_BE_EWBK = 1'b0,
    FWD_BE_WBK  = 1'b1
} fwd_be_t;

// blt compares signed
typedef enum logic [1:0] {
    BR_BEQ = 2'd0,
    BR_BNE = 2'd1,
    BR_BLT = 2'd2
} branch_cond_t;

typedef struct packed {
    logic to_dec;
    logic to_exe;
} hazard_be_t;

typedef struct packed {
    logic [PC_W-1:0] pc;
    alu_op_t         alu_op;
    rf_addr_t        rd;
    rf_addr_t        rs1;
    rf_addr_t        rs2;
    logic [XLEN-1:0] imm;
    alu_a_sel_t      alu_a_sel;
    alu_b_sel_t      alu_b_sel;
    logic            rd_we;
    logic            load_inst;
    logic            store_inst;
    logic            branch_inst;
    branch_cond_t    branch_cond;
} inst_t;

typedef struct packed {
    logic [PC_W-1:0] pc;
    rf_addr_t        rd;
    logic            rd_we;
    logic [XLEN-1:0] data;
    logic            store_inst;
    logic [XLEN-1:0] addr;
    logic            taken;
} commit_t;

endpackage

`default_nettype wire

//--- verilog/ama_riscv_inst_queue.sv
`timescale 1ns/10ps
`default_nettype none

module ama_riscv_inst_queue (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 push,
    input  ama_riscv_pkg::inst_t push_inst,
    input  logic                 pop,
    output logic                 q_valid,
    output ama_riscv_pkg::inst_t q_inst
);

import ama_riscv_pkg::*;

inst_t                  entries [QUEUE_DEPTH];
logic [QUEUE_PTR_W-1:0] wr_ptr;
logic [QUEUE_PTR_W-1:0] rd_ptr;
logic [QUEUE_PTR_W:0]   count;
logic                   do_push;
logic                   do_pop;

// a push into a full queue is lost
assign do_push = push && (int'(count) < QUEUE_DEPTH);
assign do_pop = pop && q_valid;

always_ff @(posedge clk) begin
    if (!rst_n) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count <= '0;
    end else begin
        if (do_push) wr_ptr <= wr_ptr + 1'b1;
        if (do_pop) rd_ptr <= rd_ptr + 1'b1;
        case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (do_push) entries[wr_ptr] <= push_inst;
end

// head is visible without a read cycle
assign q_valid = (count != '0);
assign q_inst = entries[rd_ptr];

endmodule

`default_nettype wire

//--- verilog/ama_riscv_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module ama_riscv_regfile (
    input  logic                              clk,
    input  logic                              rst_n,
    input  ama_riscv_pkg::rf_addr_t           rs1,
    input  ama_riscv_pkg::rf_addr_t           rs2,
    output logic [ama_riscv_pkg::XLEN-1:0]    rs1_data,
    output logic [ama_riscv_pkg::XLEN-1:0]    rs2_data,
    input  ama_riscv_pkg::rf_addr_t           rd,
    input  logic                              rd_we,
    input  logic [ama_riscv_pkg::XLEN-1:0]    rd_data
);

import ama_riscv_pkg::*;

logic [XLEN-1:0] regs [RF_NUM];

always_ff @(posedge clk) begin
    if (!rst_n) begin
        for (int i = 0; i < RF_NUM; i++) begin
            regs[i] <= '0;
        end
    end else if (rd_we && (rd != RF_X0_ZERO)) begin
        regs[rd] <= rd_data;
    end
end

// x0 is hardwired, no write-through for same cycle writes
assign rs1_data = (rs1 == RF_X0_ZERO) ? '0 : regs[rs1];
assign rs2_data = (rs2 == RF_X0_ZERO) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- verilog/ama_riscv_operand_forwarding.sv
`timescale 1ns/10ps
`default_nettype none

module ama_riscv_operand_forwarding (
    // inputs
    input  logic                      store_inst_dec,
    input  logic                      branch_inst_dec,
    input  logic                      store_inst_exe,
    input  logic                      branch_inst_exe,
    input  logic                      load_inst_mem,
    input  ama_riscv_pkg::rf_addr_t   rs1_dec,
    input  ama_riscv_pkg::rf_addr_t   rs2_dec,
    input  ama_riscv_pkg::rf_addr_t   rs1_exe,
    input  ama_riscv_pkg::rf_addr_t   rs2_exe,
    input  ama_riscv_pkg::rf_addr_t   rd_mem,
    input  ama_riscv_pkg::rf_addr_t   rd_wbk,
    input  logic                      rd_we_mem,
    input  logic                      rd_we_wbk,
    input  ama_riscv_pkg::alu_a_sel_t alu_a_sel_dec,
    input  ama_riscv_pkg::alu_b_sel_t alu_b_sel_dec,
    input  ama_riscv_pkg::alu_a_sel_t alu_a_sel_exe,
    input  ama_riscv_pkg::alu_b_sel_t alu_b_sel_exe,
    // outputs
    output ama_riscv_pkg::fwd_be_t    fwd_be_rs1_dec,
    output ama_riscv_pkg::fwd_be_t    fwd_be_rs2_dec,
    output ama_riscv_pkg::fwd_be_t    fwd_be_rs1_exe,
    output ama_riscv_pkg::fwd_be_t    fwd_be_rs2_exe,
    output ama_riscv_pkg::alu_a_sel_t alu_a_sel_fwd,
    output ama_riscv_pkg::alu_b_sel_t alu_b_sel_fwd,
    output logic                      bc_a_sel_fwd,
    output logic                      bcs_b_sel_fwd,
    output logic                      rf_a_sel_fwd,
    output logic                      rf_b_sel_fwd,
    output ama_riscv_pkg::hazard_be_t hazard_be
);

import ama_riscv_pkg::*;

// source matches a pending write, x0 never matches
function automatic logic hit(rf_addr_t src, rf_addr_t dst, logic we);
    return we && (src == dst) && (src != RF_X0_ZERO);
endfunction

logic rs1_dec_mem, rs2_dec_mem, rs1_exe_mem, rs2_exe_mem;
logic rs1_dec_wbk, rs2_dec_wbk, rs1_exe_wbk, rs2_exe_wbk;
logic rs1_dec_any, rs2_dec_any, rs1_exe_any, rs2_exe_any;

assign rs1_dec_mem = hit(rs1_dec, rd_mem, rd_we_mem);
assign rs2_dec_mem = hit(rs2_dec, rd_mem, rd_we_mem);
assign rs1_exe_mem = hit(rs1_exe, rd_mem, rd_we_mem);
assign rs2_exe_mem = hit(rs2_exe, rd_mem, rd_we_mem);
assign rs1_dec_wbk = hit(rs1_dec, rd_wbk, rd_we_wbk);
assign rs2_dec_wbk = hit(rs2_dec, rd_wbk, rd_we_wbk);
assign rs1_exe_wbk = hit(rs1_exe, rd_wbk, rd_we_wbk);
assign rs2_exe_wbk = hit(rs2_exe, rd_wbk, rd_we_wbk);

assign rs1_dec_any = rs1_dec_mem || rs1_dec_wbk;
assign rs2_dec_any = rs2_dec_mem || rs2_dec_wbk;
assign rs1_exe_any = rs1_exe_mem || rs1_exe_wbk;
assign rs2_exe_any = rs2_exe_mem || rs2_exe_wbk;

// younger producer in mem shadows the one in writeback
assign fwd_be_rs1_dec = rs1_dec_mem ? FWD_BE_EWBK : FWD_BE_WBK;
assign fwd_be_rs2_dec = rs2_dec_mem ? FWD_BE_EWBK : FWD_BE_WBK;
assign fwd_be_rs1_exe = rs1_exe_mem ? FWD_BE_EWBK : FWD_BE_WBK;
assign fwd_be_rs2_exe = rs2_exe_mem ? FWD_BE_EWBK : FWD_BE_WBK;

always_comb begin
    alu_a_sel_fwd = alu_a_sel_exe;
    alu_b_sel_fwd = alu_b_sel_exe;
    // only register operands get replaced, pc and imm pass through
    if (rs1_exe_any && (alu_a_sel_exe == ALU_A_SEL_RS1)) alu_a_sel_fwd = ALU_A_SEL_FWD;
    if (rs2_exe_any && (alu_b_sel_exe == ALU_B_SEL_RS2)) alu_b_sel_fwd = ALU_B_SEL_FWD;
end

// compare operands and store data in execute
assign bc_a_sel_fwd = rs1_exe_any && branch_inst_exe;
assign bcs_b_sel_fwd = rs2_exe_any && (branch_inst_exe || store_inst_exe);

// decode operands captured into execute
assign rf_a_sel_fwd = rs1_dec_any && (branch_inst_dec || (alu_a_sel_dec == ALU_A_SEL_RS1));
assign rf_b_sel_fwd = rs2_dec_any &&
    (branch_inst_dec || store_inst_dec || (alu_b_sel_dec == ALU_B_SEL_RS2));

// load data is not ready in mem, wait one cycle and take it from writeback
always_comb begin
    hazard_be.to_exe = load_inst_mem && (rs1_exe_mem || rs2_exe_mem);
    hazard_be.to_dec = load_inst_mem && (rs1_dec_mem || rs2_dec_mem);
end

endmodule

`default_nettype wire

//--- verilog/ama_riscv_dmem.sv
`timescale 1ns/10ps
`default_nettype none

module ama_riscv_dmem (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic [ama_riscv_pkg::DMEM_ADDR_W-1:0] addr,
    input  logic                                 we,
    input  logic [ama_riscv_pkg::XLEN-1:0]       wdata,
    output logic [ama_riscv_pkg::XLEN-1:0]       rdata
);

import ama_riscv_pkg::*;

logic [XLEN-1:0] words [DMEM_DEPTH];

always_ff @(posedge clk) begin
    if (!rst_n) begin
        for (int i = 0; i < DMEM_DEPTH; i++) begin
            words[i] <= '0;
        end
    end else if (we) begin
        words[addr] <= wdata;
    end
end

// load data available in the same cycle
assign rdata = words[addr];

endmodule

`default_nettype wire

//--- verilog/ama_riscv_pipeline.sv
`timescale 1ns/10ps
`default_nettype none

module ama_riscv_pipeline (
    input  logic                                  clk,
    input  logic                                  rst_n,
    // instruction queue
    input  logic                                  q_valid,
    input  ama_riscv_pkg::inst_t                  q_inst,
    output logic                                  pop,
    // register file
    output ama_riscv_pkg::rf_addr_t               rf_rs1, rf_rs2, rf_rd,
    input  logic [ama_riscv_pkg::XLEN-1:0]        rf_rs1_data, rf_rs2_data,
    output logic                                  rf_rd_we,
    output logic [ama_riscv_pkg::XLEN-1:0]        rf_rd_data,
    // data memory
    output logic [ama_riscv_pkg::DMEM_ADDR_W-1:0] dmem_addr,
    output logic                                  dmem_we,
    output logic [ama_riscv_pkg::XLEN-1:0]        dmem_wdata,
    input  logic [ama_riscv_pkg::XLEN-1:0]        dmem_rdata,
    // from the forwarding unit
    input  ama_riscv_pkg::fwd_be_t     fwd_be_rs1_dec, fwd_be_rs2_dec,
    input  ama_riscv_pkg::fwd_be_t     fwd_be_rs1_exe, fwd_be_rs2_exe,
    input  ama_riscv_pkg::alu_a_sel_t  alu_a_sel_fwd,
    input  ama_riscv_pkg::alu_b_sel_t  alu_b_sel_fwd,
    input  logic                       bc_a_sel_fwd, bcs_b_sel_fwd, rf_a_sel_fwd, rf_b_sel_fwd,
    input  ama_riscv_pkg::hazard_be_t  hazard_be,
    // to the forwarding unit
    output logic                       store_inst_dec, branch_inst_dec, load_inst_mem,
    output logic                       store_inst_exe, branch_inst_exe,
    output ama_riscv_pkg::rf_addr_t    rs1_dec, rs2_dec, rs1_exe, rs2_exe, rd_mem, rd_wbk,
    output logic                       rd_we_mem, rd_we_wbk,
    output ama_riscv_pkg::alu_a_sel_t  alu_a_sel_dec, alu_a_sel_exe,
    output ama_riscv_pkg::alu_b_sel_t  alu_b_sel_dec, alu_b_sel_exe,
    // retire
    output logic                       commit_valid,
    output ama_riscv_pkg::commit_t     commit
);

import ama_riscv_pkg::*;

logic            valid_dec, valid_exe, valid_mem, valid_wbk;
inst_t           inst_dec, inst_exe, inst_mem, inst_wbk;
logic [XLEN-1:0] rs1_val_exe, rs2_val_exe, alu_mem, sdata_mem, data_wbk, addr_wbk;
logic            taken_mem, taken_wbk;
logic            stall_dec, stall_exe;
logic [XLEN-1:0] fwd_rs1_dec, fwd_rs2_dec, rs1_val_dec, rs2_val_dec;
logic [XLEN-1:0] fwd_rs1_exe, fwd_rs2_exe, rs1_res_exe, rs2_res_exe;
logic [XLEN-1:0] alu_a, alu_b, alu_out, mem_result;
logic            cond, taken_exe;

// load-use in exe freezes dec and exe, load-use in dec freezes dec only
assign stall_exe = hazard_be.to_exe;
assign stall_dec = hazard_be.to_exe || hazard_be.to_dec;
assign pop = q_valid && !stall_dec;

// empty stages present x0 so they never match
assign rs1_dec = valid_dec ? inst_dec.rs1 : RF_X0_ZERO;
assign rs2_dec = valid_dec ? inst_dec.rs2 : RF_X0_ZERO;
assign rs1_exe = valid_exe ? inst_exe.rs1 : RF_X0_ZERO;
assign rs2_exe = valid_exe ? inst_exe.rs2 : RF_X0_ZERO;
assign store_inst_dec = valid_dec && inst_dec.store_inst;
assign branch_inst_dec = valid_dec && inst_dec.branch_inst;
assign store_inst_exe = valid_exe && inst_exe.store_inst;
assign branch_inst_exe = valid_exe && inst_exe.branch_inst;
assign alu_a_sel_dec = inst_dec.alu_a_sel;
assign alu_b_sel_dec = inst_dec.alu_b_sel;
assign alu_a_sel_exe = inst_exe.alu_a_sel;
assign alu_b_sel_exe = inst_exe.alu_b_sel;
assign rd_mem = inst_mem.rd;
assign rd_we_mem = valid_mem && inst_mem.rd_we;
assign load_inst_mem = valid_mem && inst_mem.load_inst;
assign rd_wbk = inst_wbk.rd;
assign rd_we_wbk = valid_wbk && inst_wbk.rd_we;

// decode operands
assign rf_rs1 = inst_dec.rs1;
assign rf_rs2 = inst_dec.rs2;
assign fwd_rs1_dec = (fwd_be_rs1_dec == FWD_BE_EWBK) ? alu_mem : data_wbk;
assign fwd_rs2_dec = (fwd_be_rs2_dec == FWD_BE_EWBK) ? alu_mem : data_wbk;
assign rs1_val_dec = rf_a_sel_fwd ? fwd_rs1_dec : rf_rs1_data;
assign rs2_val_dec = rf_b_sel_fwd ? fwd_rs2_dec : rf_rs2_data;

// execute operands, also written back while exe is frozen
assign fwd_rs1_exe = (fwd_be_rs1_exe == FWD_BE_EWBK) ? alu_mem : data_wbk;
assign fwd_rs2_exe = (fwd_be_rs2_exe == FWD_BE_EWBK) ? alu_mem : data_wbk;
assign rs1_res_exe = ((alu_a_sel_fwd == ALU_A_SEL_FWD) || bc_a_sel_fwd) ?
    fwd_rs1_exe : rs1_val_exe;
assign rs2_res_exe = ((alu_b_sel_fwd == ALU_B_SEL_FWD) || bcs_b_sel_fwd) ?
    fwd_rs2_exe : rs2_val_exe;

always_comb begin
    case (alu_a_sel_fwd)
        ALU_A_SEL_PC:  alu_a = {{(XLEN-PC_W){1'b0}}, inst_exe.pc};
        ALU_A_SEL_FWD: alu_a = fwd_rs1_exe;
        default:       alu_a = rs1_val_exe;
    endcase
    case (alu_b_sel_fwd)
        ALU_B_SEL_IMM: alu_b = inst_exe.imm;
        ALU_B_SEL_FWD: alu_b = fwd_rs2_exe;
        default:       alu_b = rs2_val_exe;
    endcase
    case (inst_exe.alu_op)
        ALU_SUB: alu_out = alu_a - alu_b;
        ALU_AND: alu_out = alu_a & alu_b;
        ALU_OR:  alu_out = alu_a | alu_b;
        ALU_XOR: alu_out = alu_a ^ alu_b;
        ALU_SLL: alu_out = alu_a << alu_b[4:0];
        ALU_SRL: alu_out = alu_a >> alu_b[4:0];
        ALU_SLT: alu_out = {{(XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
        default: alu_out = alu_a + alu_b;
    endcase
    case (inst_exe.branch_cond)
        BR_BNE:  cond = (rs1_res_exe != rs2_res_exe);
        BR_BLT:  cond = ($signed(rs1_res_exe) < $signed(rs2_res_exe));
        default: cond = (rs1_res_exe == rs2_res_exe);
    endcase
end

assign taken_exe = inst_exe.branch_inst && cond;

// memory stage
assign dmem_addr = alu_mem[DMEM_ADDR_W+1:2];
assign dmem_we = valid_mem && inst_mem.store_inst;
assign dmem_wdata = sdata_mem;

always_comb begin
    if (inst_mem.load_inst) mem_result = dmem_rdata;
    else if (inst_mem.store_inst) mem_result = sdata_mem;
    else if (inst_mem.branch_inst) mem_result = '0;
    else mem_result = alu_mem;
end

always_ff @(posedge clk) begin
    if (!rst_n) begin
        valid_dec <= 1'b0;
        valid_exe <= 1'b0;
        valid_mem <= 1'b0;
        valid_wbk <= 1'b0;
    end else begin
        if (!stall_dec) valid_dec <= q_valid;
        if (!stall_exe) valid_exe <= valid_dec && !stall_dec;
        valid_mem <= valid_exe && !stall_exe;
        valid_wbk <= valid_mem;
    end
end

always_ff @(posedge clk) begin
    if (pop) inst_dec <= q_inst;
    if (stall_exe) begin
        rs1_val_exe <= rs1_res_exe;
        rs2_val_exe <= rs2_res_exe;
    end else begin
        inst_exe <= inst_dec;
        rs1_val_exe <= rs1_val_dec;
        rs2_val_exe <= rs2_val_dec;
    end
    inst_mem <= inst_exe;
    alu_mem <= alu_out;
    sdata_mem <= rs2_res_exe;
    taken_mem <= taken_exe;
    inst_wbk <= inst_mem;
    addr_wbk <= alu_mem;
    data_wbk <= mem_result;
    taken_wbk <= taken_mem;
end

// writeback
assign rf_rd = inst_wbk.rd;
assign rf_rd_we = rd_we_wbk;
assign rf_rd_data = data_wbk;
assign commit_valid = valid_wbk;
assign commit = '{pc: inst_wbk.pc, rd: inst_wbk.rd, rd_we: inst_wbk.rd_we, data: data_wbk,
    store_inst: inst_wbk.store_inst, addr: addr_wbk, taken: taken_wbk};

endmodule

`default_nettype wire

//--- verilog/ama_riscv_backend_top.sv
`timescale 1ns/10ps
`default_nettype none

module ama_riscv_backend_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   inst_valid,
    input  ama_riscv_pkg::inst_t   inst,
    output logic                   commit_valid,
    output ama_riscv_pkg::commit_t commit
);

import ama_riscv_pkg::*;

logic                   q_valid, pop;
inst_t                  q_inst;
rf_addr_t               rf_rs1, rf_rs2, rf_rd;
logic [XLEN-1:0]        rf_rs1_data, rf_rs2_data, rf_rd_data;
logic                   rf_rd_we;
logic [DMEM_ADDR_W-1:0] dmem_addr;
logic                   dmem_we;
logic [XLEN-1:0]        dmem_wdata, dmem_rdata;
fwd_be_t                fwd_be_rs1_dec, fwd_be_rs2_dec, fwd_be_rs1_exe, fwd_be_rs2_exe;
alu_a_sel_t             alu_a_sel_fwd, alu_a_sel_dec, alu_a_sel_exe;
alu_b_sel_t             alu_b_sel_fwd, alu_b_sel_dec, alu_b_sel_exe;
logic                   bc_a_sel_fwd, bcs_b_sel_fwd, rf_a_sel_fwd, rf_b_sel_fwd;
hazard_be_t             hazard_be;
logic                   store_inst_dec, branch_inst_dec, store_inst_exe, branch_inst_exe;
logic                   load_inst_mem, rd_we_mem, rd_we_wbk;
rf_addr_t               rs1_dec, rs2_dec, rs1_exe, rs2_exe, rd_mem, rd_wbk;

ama_riscv_inst_queue ama_riscv_inst_queue_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (inst_valid),
    .push_inst (inst),
    .pop       (pop),
    .q_valid   (q_valid),
    .q_inst    (q_inst)
);

// stage fields and forwarding selects share names across both blocks
ama_riscv_pipeline ama_riscv_pipeline_i (.*);

ama_riscv_operand_forwarding ama_riscv_operand_forwarding_i (.*);

ama_riscv_regfile ama_riscv_regfile_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1      (rf_rs1),
    .rs2      (rf_rs2),
    .rs1_data (rf_rs1_data),
    .rs2_data (rf_rs2_data),
    .rd       (rf_rd),
    .rd_we    (rf_rd_we),
    .rd_data  (rf_rd_data)
);

ama_riscv_dmem ama_riscv_dmem_i (
    .clk   (clk),
    .rst_n (rst_n),
    .addr  (dmem_addr),
    .we    (dmem_we),
    .wdata (dmem_wdata),
    .rdata (dmem_rdata)
);

endmodule

`default_nettype wire

//--- dv/ama_riscv_ref_model.svh
`ifndef AMA_RISCV_REF_MODEL_SVH
`define AMA_RISCV_REF_MODEL_SVH

// architectural state, updated one instruction at a time in issue order
logic [XLEN-1:0] ref_regs [RF_NUM];
logic [XLEN-1:0] ref_mem [DMEM_DEPTH];

function automatic void ref_reset();
    for (int r = 0; r < RF_NUM; r++) begin
        ref_regs[r] = '0;
    end
    for (int w = 0; w < DMEM_DEPTH; w++) begin
        ref_mem[w] = '0;
    end
endfunction

function automatic commit_t ref_exec(input inst_t i);
    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] res;
    commit_t         c;
    src1 = ref_regs[i.rs1];
    src2 = ref_regs[i.rs2];
    op_a = (i.alu_a_sel == ALU_A_SEL_PC) ? {16'h0000, i.pc} : src1;
    op_b = (i.alu_b_sel == ALU_B_SEL_IMM) ? i.imm : src2;
    case (i.alu_op)
        ALU_ADD: res = op_a + op_b;
        ALU_SUB: res = op_a + ~op_b + 32'd1;
        ALU_AND: res = op_a & op_b;
        ALU_OR:  res = op_a | op_b;
        ALU_XOR: res = op_a ^ op_b;
        ALU_SLL: res = op_a << op_b[4:0];
        ALU_SRL: res = op_a >> op_b[4:0];
        default: res = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
    endcase
    c = '0;
    c.pc = i.pc;
    c.rd = i.rd;
    c.rd_we = i.rd_we;
    c.store_inst = i.store_inst;
    c.addr = res;
    if (i.load_inst) begin
        c.data = ref_mem[res[7:2]];
    end else if (i.store_inst) begin
        c.data = src2;
        ref_mem[res[7:2]] = src2;
    end else if (i.branch_inst) begin
        // blt is a signed compare
        case (i.branch_cond)
            BR_BNE:  c.taken = (src1 != src2);
            BR_BLT:  c.taken = ($signed(src1) < $signed(src2));
            default: c.taken = (src1 == src2);
        endcase
    end else begin
        c.data = res;
    end
    if (i.rd_we && (i.rd != RF_X0_ZERO)) ref_regs[i.rd] = c.data;
    return c;
endfunction

`endif

//--- dv/ama_riscv_backend_tb.sv
`timescale 1ns/10ps
`default_nettype none

module ama_riscv_backend_tb;

import ama_riscv_pkg::*;

`include "ama_riscv_ref_model.svh"

localparam int DRAIN_TIMEOUT = 200;
localparam int RANDOM_COUNT = 300;

logic            clk;
logic            rst_n;
logic            inst_valid;
inst_t           inst;
logic            commit_valid;
commit_t         commit;

inst_t           pending [$];
commit_t         expected;
int              errors;
int              issued;
int              commits;
logic [31:0]     lcg_state;
logic [PC_W-1:0] next_pc;

ama_riscv_backend_top ama_riscv_backend_top_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .inst_valid   (inst_valid),
    .inst         (inst),
    .commit_valid (commit_valid),
    .commit       (commit)
);

initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
end

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
endfunction

// upper bits, the low bits of the lcg repeat too soon
function automatic int pick(input int n);
    logic [31:0] r;
    r = lcg_next();
    return int'(r[30:16]) % n;
endfunction

function automatic inst_t alu_inst(input alu_op_t op, input rf_addr_t rd, input rf_addr_t rs1,
                                   input rf_addr_t rs2, input alu_a_sel_t a_sel,
                                   input alu_b_sel_t b_sel, input logic [XLEN-1:0] imm);
    inst_t i;
    i = '0;
    i.alu_op = op;
    i.rd = rd;
    i.rs1 = rs1;
    i.rs2 = rs2;
    i.imm = imm;
    i.alu_a_sel = a_sel;
    i.alu_b_sel = b_sel;
    i.rd_we = 1'b1;
    return i;
endfunction

function automatic inst_t load_word(input rf_addr_t rd, input rf_addr_t base,
                                    input logic [XLEN-1:0] offset);
    inst_t i;
    i = alu_inst(ALU_ADD, rd, base, RF_X0_ZERO, ALU_A_SEL_RS1, ALU_B_SEL_IMM, offset);
    i.load_inst = 1'b1;
    return i;
endfunction

function automatic inst_t store_word(input rf_addr_t base, input rf_addr_t src,
                                     input logic [XLEN-1:0] offset);
    inst_t i;
    i = alu_inst(ALU_ADD, RF_X0_ZERO, base, src, ALU_A_SEL_RS1, ALU_B_SEL_IMM, offset);
    i.rd_we = 1'b0;
    i.store_inst = 1'b1;
    return i;
endfunction

function automatic inst_t branch_cmp(input branch_cond_t cond, input rf_addr_t rs1,
                                     input rf_addr_t rs2);
    inst_t i;
    i = alu_inst(ALU_ADD, RF_X0_ZERO, rs1, rs2, ALU_A_SEL_RS1, ALU_B_SEL_IMM, 32'h0);
    i.rd_we = 1'b0;
    i.branch_inst = 1'b1;
    i.branch_cond = cond;
    return i;
endfunction

// registers x0..x5 only, so dependences come often
function automatic inst_t random_inst();
    int              kind;
    rf_addr_t        rd;
    rf_addr_t        rs1;
    rf_addr_t        rs2;
    logic [XLEN-1:0] imm;
    alu_op_t         op;
    kind = pick(8);
    rd = rf_addr_t'(pick(6));
    rs1 = rf_addr_t'(pick(6));
    rs2 = rf_addr_t'(pick(6));
    imm = lcg_next();
    op = alu_op_t'(pick(8));
    case (kind)
        0:       return load_word(rd, rs1, imm);
        1:       return store_word(rs1, rs2, imm);
        2:       return branch_cmp(branch_cond_t'(pick(3)), rs1, rs2);
        3:       return alu_inst(op, rd, rs1, rs2, ALU_A_SEL_PC, ALU_B_SEL_IMM, imm);
        4, 5:    return alu_inst(op, rd, rs1, rs2, ALU_A_SEL_RS1, ALU_B_SEL_IMM, imm);
        default: return alu_inst(op, rd, rs1, rs2, ALU_A_SEL_RS1, ALU_B_SEL_RS2, imm);
    endcase
endfunction

// one strobe, then gap idle cycles
task automatic issue(input inst_t i, input int gap);
    i.pc = next_pc;
    next_pc = next_pc + 16'd4;
    inst = i;
    inst_valid = 1'b1;
    pending.push_back(i);
    issued++;
    @(negedge clk);
    inst_valid = 1'b0;
    repeat (gap) @(negedge clk);
endtask

task automatic check_data(input string name, input logic [XLEN-1:0] exp,
                          input logic [XLEN-1:0] act);
    if (act !== exp) begin
        $display("Mismatch %s: expected %h, got %h at %0t", name, exp, act, $time);
        errors++;
    end
endtask

task automatic check_commit(input commit_t exp, input commit_t act);
    check_data("commit.pc", XLEN'(exp.pc), XLEN'(act.pc));
    check_data("commit.rd", XLEN'(exp.rd), XLEN'(act.rd));
    check_data("commit.rd_we", XLEN'(exp.rd_we), XLEN'(act.rd_we));
    check_data("commit.store_inst", XLEN'(exp.store_inst), XLEN'(act.store_inst));
    check_data("commit.addr", exp.addr, act.addr);
    check_data("commit.taken", XLEN'(exp.taken), XLEN'(act.taken));
endtask

task automatic run_directed();
    // independent operations, x0 as destination, pc as operand a
    issue(alu_inst(ALU_ADD, 5'd1, 5'd0, 5'd0, ALU_A_SEL_RS1, ALU_B_SEL_IMM, 32'h0000_0123), 4);
    issue(alu_inst(ALU_ADD, 5'd2, 5'd0, 5'd0, ALU_A_SEL_RS1, ALU_B_SEL_IMM, 32'h8000_0f05), 4);
    issue(alu_inst(ALU_ADD, 5'd3, 5'd0, 5'd0, ALU_A_SEL_PC, ALU_B_SEL_IMM, 32'h0000_0010), 4);
    issue(alu_inst(ALU_ADD, 5'd0, 5'd1, 5'd0, ALU_A_SEL_RS1, ALU_B_SEL_IMM, 32'h0000_0055), 1);
    issue(alu_inst(ALU_OR, 5'd4, 5'd0, 5'd0, ALU_A_SEL_RS1, ALU_B_SEL_IMM, 32'h0000_0007), 4);
    for (int k = 0; k < 8; k++) begin
        issue(alu_inst(alu_op_t'(k), rf_addr_t'(5 + k), 5'd1, 5'd2,
                       ALU_A_SEL_RS1, ALU_B_SEL_RS2, 32'h0), 4);
    end
    // chains at the minimum gap
    issue(alu_inst(ALU_ADD, 5'd11, 5'd1, 5'd0, ALU_A_SEL_RS1, ALU_B_SEL_IMM, 32'h1), 1);
    issue(alu_inst(ALU_ADD, 5'd11, 5'd11, 5'd11, ALU_A_SEL_RS1, ALU_B_SEL_RS2, 32'h0), 1);
    issue(alu_inst(ALU_SUB, 5'd12, 5'd11, 5'd1, ALU_A_SEL_RS1, ALU_B_SEL_RS2, 32'h0), 1);
    issue(alu_inst(ALU_XOR, 5'd12, 5'd11, 5'd12, ALU_A_SEL_RS1, ALU_B_SEL_RS2, 32'h0), 1);
    // the load-use stall closes the gap, so both x14 writes sit in mem and writeback
    issue(load_word(5'd13, 5'd0, 32'h20), 1);
    issue(alu_inst(ALU_ADD, 5'd14, 5'd13, 5'd0, ALU_A_SEL_RS1, ALU_B_SEL_IMM, 32'h5), 1);
    issue(alu_inst(ALU_ADD, 5'd14, 5'd0, 5'd0, ALU_A_SEL_RS1, ALU_B_SEL_IMM, 32'h9), 1);
    issue(alu_inst(ALU_ADD, 5'd15, 5'd14, 5'd14, ALU_A_SEL_RS1, ALU_B_SEL_RS2, 32'h0), 1);
    // load followed by its user
    issue(store_word(5'd0, 5'd1, 32'h20), 1);
    issue(load_word(5'd16, 5'd0, 32'h20), 1);
    issue(alu_inst(ALU_ADD, 5'd17, 5'd16, 5'd16, ALU_A_SEL_RS1, ALU_B_SEL_RS2, 32'h0), 1);
    issue(load_word(5'd18, 5'd0, 32'h20), 1);
    issue(branch_cmp(BR_BEQ, 5'd18, 5'd1), 1);
    // store data produced by the instruction just before it
    issue(alu_inst(ALU_ADD, 5'd19, 5'd1, 5'd0, ALU_A_SEL_RS1, ALU_B_SEL_IMM, 32'h11), 1);
    issue(store_word(5'd2, 5'd19, 32'h40), 1);
    issue(load_word(5'd20, 5'd2, 32'h40), 1);
    issue(alu_inst(ALU_OR, 5'd21, 5'd20, 5'd0, ALU_A_SEL_RS1, ALU_B_SEL_RS2, 32'h0), 1);
    // branch compares on forwarded operands
    issue(alu_inst(ALU_ADD, 5'd22, 5'd0, 5'd0, ALU_A_SEL_RS1, ALU_B_SEL_IMM, 32'h3), 1);
    issue(branch_cmp(BR_BEQ, 5'd22, 5'd22), 1);
    issue(branch_cmp(BR_BNE, 5'd22, 5'd1), 1);
    issue(branch_cmp(BR_BLT, 5'd2, 5'd22), 1);
    issue(branch_cmp(BR_BLT, 5'd22, 5'd2), 1);
    issue(branch_cmp(BR_BNE, 5'd22, 5'd22), 4);
endtask

// commits are compared against the reference in issue order
always @(negedge clk) begin
    if (rst_n && commit_valid) begin
        commits++;
        if (pending.size() == 0) begin
            $display("commit for pc %h arrived with no instruction outstanding", commit.pc);
            errors++;
        end else begin
            expected = ref_exec(pending.pop_front());
            check_commit(expected, commit);
            check_data("commit.data", expected.data, commit.data);
        end
    end
end

initial begin
    int wait_cycles;
    lcg_state = 32'd85;
    next_pc = '0;
    errors = 0;
    issued = 0;
    commits = 0;
    rst_n = 1'b0;
    inst_valid = 1'b0;
    inst = '0;
    ref_reset();
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    run_directed();
    for (int n = 0; n < RANDOM_COUNT; n++) begin
        issue(random_inst(), 1 + pick(3));
    end

    wait_cycles = 0;
    while ((commits < issued) && (wait_cycles < DRAIN_TIMEOUT)) begin
        @(negedge clk);
        wait_cycles++;
    end
    if (commits < issued) begin
        $display("timeout: %0d of %0d instructions never committed", issued - commits, issued);
        errors++;
    end
    // late extra commits would show up here
    repeat (4) @(negedge clk);
    if (commits != issued) begin
        $display("commit count %0d differs from issue count %0d", commits, issued);
        errors++;
    end

    $display("errors=%0d commits=%0d issued=%0d", errors, commits, issued);
    if (errors == 0) begin
        $display("Simulation passed");
    end else begin
        $display("Simulation failed");
    end
    $finish;
end

endmodule

`default_nettype wire

//--- ama_riscv_backend_top.f
+incdir+dv
verilog/ama_riscv_pkg.sv
verilog/ama_riscv_inst_queue.sv
verilog/ama_riscv_regfile.sv
verilog/ama_riscv_operand_forwarding.sv
verilog/ama_riscv_dmem.sv
verilog/ama_riscv_pipeline.sv
verilog/ama_riscv_backend_top.sv
dv/ama_riscv_backend_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --top-module ama_riscv_backend_tb \
    -f ama_riscv_backend_top.f -o ama_riscv_backend_sim
./obj_dir/ama_riscv_backend_sim | tee sim.log

if grep -q "^Simulation passed$" sim.log; then
    exit 0
fi
echo "run_sim.sh: pass message not found in sim.log"
exit 1
